//--- design/fe_pkg.sv
// fetch front end package
`default_nettype none

package fe_pkg;

  // datapath widths, rv32 only
  localparam int PC_WD        = 32;
  localparam int INST_WD      = 32;
  localparam int SRAM_ADDR_WD = 32;
  localparam int SRAM_DATA_WD = 64; // two instructions per sram word

  // first fetch address after reset
  localparam logic [PC_WD-1:0] PC_RESETVAL = 32'h8000_0000;

  // major opcodes
  localparam logic [6:0] OPC_JAL = 7'b110_1111;

  // redirect from decode back to the pc
  typedef struct packed {
    logic             stall;  // force the pc to load
    logic             sel;    // take target instead of pc + 4
    logic [PC_WD-1:0] target;
  } br_bus_t;

  // one instruction with its pc, fs->ds and ds->es
  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [PC_WD-1:0]   pc;
  } inst_bus_t;

endpackage

`default_nettype wire

//--- design/fe_pc.sv
// program counter
`timescale 1ns/1ps
`default_nettype none

module fe_pc (
  input  wire                              i_clk,
  input  wire                              i_reset,
  input  wire                              i_load,
  input  wire fe_pkg::br_bus_t             i_br,
  output logic [fe_pkg::PC_WD-1:0]         o_pc,
  // inst sram read port
  output logic                             o_inst_sram_ren,
  output logic [fe_pkg::SRAM_ADDR_WD-1:0]  o_inst_sram_addr
);

  logic [fe_pkg::PC_WD-1:0] pc;
  logic [fe_pkg::PC_WD-1:0] seq_pc;
  logic [fe_pkg::PC_WD-1:0] nxt_pc;
  logic                     ren_q;

  assign seq_pc = pc + 32'd4;
  assign nxt_pc = i_br.sel ? i_br.target : seq_pc; // jal redirect wins

  // repeat the current pc while held so rdata stays put
  assign o_inst_sram_addr = i_load ? nxt_pc : pc;
  assign o_inst_sram_ren  = ren_q;
  assign o_pc             = pc;

  // ren comes up one cycle after reset drops
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ren_q <= 1'b0;
    end else begin
      ren_q <= 1'b1;
    end
  end

  // reset value sits one slot below the first fetch address
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc <= fe_pkg::PC_RESETVAL - 32'd4;
    end else if (i_load) begin
      pc <= nxt_pc;
    end
  end

endmodule

`default_nettype wire

//--- design/fe_if_stage.sv
// instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fe_if_stage (
  input  wire                                i_clk,
  input  wire                                i_reset,
  // allowin from decode
  input  wire                                i_ds_allowin,
  // redirect from decode
  input  wire fe_pkg::br_bus_t               i_br,
  // to decode
  output logic                               o_fs_to_ds_valid,
  output fe_pkg::inst_bus_t                  o_fs_to_ds_bus,
  // inst sram
  output logic                               o_inst_sram_ren,
  output logic [fe_pkg::SRAM_ADDR_WD-1:0]    o_inst_sram_addr,
  input  wire  [fe_pkg::SRAM_DATA_WD-1:0]    i_inst_sram_rdata
);

  logic                       to_fs_valid;
  logic                       fs_valid;
  logic                       fs_allowin;
  logic                       pc_load;
  logic [fe_pkg::PC_WD-1:0]   fs_pc;
  logic [fe_pkg::INST_WD-1:0] fs_inst;

  // ren is low through reset and one cycle beyond
  assign to_fs_valid = o_inst_sram_ren;

  // stage completes in one cycle, so no ready_go term
  assign fs_allowin = !fs_valid || i_ds_allowin;

  // a redirect reloads the pc even when decode is blocked
  assign pc_load = (to_fs_valid && fs_allowin) || i_br.stall;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin || i_br.stall) begin
      fs_valid <= to_fs_valid;
    end
  end

  fe_pc u_pc (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_load           (pc_load),
    .i_br             (i_br),
    .o_pc             (fs_pc),
    .o_inst_sram_ren  (o_inst_sram_ren),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  // 64-bit word, pc[2] picks the half
  assign fs_inst = fs_pc[2] ? i_inst_sram_rdata[63:32] : i_inst_sram_rdata[31:0];

  assign o_fs_to_ds_valid    = fs_valid;
  assign o_fs_to_ds_bus.inst = fs_inst;
  assign o_fs_to_ds_bus.pc   = fs_pc;

  // a pending item stays put until decode takes it or a jal replaces it
  a_fs_hold : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (o_fs_to_ds_valid && !i_ds_allowin && !i_br.stall)
      |=> (o_fs_to_ds_valid && $stable(o_fs_to_ds_bus.pc))
  );

endmodule

`default_nettype wire

//--- design/fe_id_stage.sv
// instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module fe_id_stage (
  input  wire                    i_clk,
  input  wire                    i_reset,
  // from fetch
  input  wire                    i_fs_to_ds_valid,
  input  wire fe_pkg::inst_bus_t i_fs_to_ds_bus,
  output logic                   o_ds_allowin,
  // redirect to fetch
  output fe_pkg::br_bus_t        o_br,
  // to execute
  input  wire                    i_es_allowin,
  output logic                   o_ds_to_es_valid,
  output fe_pkg::inst_bus_t      o_ds_to_es_bus
);

  logic                       ds_valid;
  logic                       ds_allowin;
  logic                       ds_take;
  fe_pkg::inst_bus_t          ds_bus;
  logic                       is_jal;
  logic [fe_pkg::PC_WD-1:0]   j_imm;
  logic                       br_done;  // redirect already sent for held jal
  logic                       br_sel;

  assign ds_allowin = !ds_valid || i_es_allowin;

  // fetch item in the redirect cycle is wrong-path
  assign ds_take = i_fs_to_ds_valid && !br_sel;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= ds_take;
    end
  end

  // payload, no reset
  always_ff @(posedge i_clk) begin
    if (ds_allowin && ds_take) begin
      ds_bus <= i_fs_to_ds_bus;
    end
  end

  // jal decode
  assign is_jal = ds_bus.inst[6:0] == fe_pkg::OPC_JAL;
  assign j_imm  = {{12{ds_bus.inst[31]}}, ds_bus.inst[19:12], ds_bus.inst[20],
                   ds_bus.inst[30:21], 1'b0};

  // one redirect per jal, even if execute holds it for a while
  assign br_sel = ds_valid && is_jal && !br_done;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      br_done <= 1'b0;
    end else if (ds_allowin) begin
      br_done <= 1'b0;   // jal leaves or slot refills
    end else if (br_sel) begin
      br_done <= 1'b1;
    end
  end

  assign o_br.stall  = br_sel;
  assign o_br.sel    = br_sel;
  assign o_br.target = ds_bus.pc + j_imm;

  assign o_ds_allowin     = ds_allowin;
  assign o_ds_to_es_valid = ds_valid;
  assign o_ds_to_es_bus   = ds_bus;

  // only one redirect cycle per jal
  a_sel_pulse : assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_br.sel |=> !o_br.sel
  );

endmodule

`default_nettype wire

//--- design/fe_top.sv
// fetch front end top
`timescale 1ns/1ps
`default_nettype none

module fe_top (
  input  wire                                i_clk,
  input  wire                                i_reset,
  // inst sram
  output logic                               o_inst_sram_ren,
  output logic [fe_pkg::SRAM_ADDR_WD-1:0]    o_inst_sram_addr,
  input  wire  [fe_pkg::SRAM_DATA_WD-1:0]    i_inst_sram_rdata,
  // execute side
  input  wire                                i_es_allowin,
  output logic                               o_ds_to_es_valid,
  output fe_pkg::inst_bus_t                  o_ds_to_es_bus
);

  logic              fs_to_ds_valid;
  fe_pkg::inst_bus_t fs_to_ds_bus;
  logic              ds_allowin;
  fe_pkg::br_bus_t   br_bus;

  fe_if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_ds_allowin      (ds_allowin),
    .i_br              (br_bus),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_to_ds_bus    (fs_to_ds_bus),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  fe_id_stage u_id_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds_bus   (fs_to_ds_bus),
    .o_ds_allowin     (ds_allowin),
    .o_br             (br_bus),
    .i_es_allowin     (i_es_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es_bus   (o_ds_to_es_bus)
  );

endmodule

`default_nettype wire

//--- dv/fe_inst_mem.sv
// instruction sram model
`timescale 1ns/1ps
`default_nettype none

module fe_inst_mem (
  input  wire         i_clk,
  input  wire         i_ren,
  input  wire  [31:0] i_addr,
  output logic [63:0] o_rdata
);

  localparam int          DEPTH = 64;             // doublewords, 512 bytes
  localparam logic [31:0] BASE  = 32'h8000_0000;

  logic [63:0] mem [DEPTH];

  // addi with the whole address folded into rd, rs1 and imm, never a jal
  function automatic logic [31:0] fill_inst(input logic [31:0] addr);
    return {addr[31:7] ^ {addr[6:0], addr[31:14]}, 7'b001_0011};
  endfunction

  // doubleword holding addr, outside the array only the fill pattern
  function automatic logic [63:0] read_word(input logic [31:0] addr);
    logic [31:0] dw;
    dw = {addr[31:3], 3'b000};
    if (dw[31:9] == BASE[31:9]) begin
      return mem[dw[8:3]];
    end
    return {fill_inst(dw + 32'd4), fill_inst(dw)};
  endfunction

  task automatic clear();
    int k;
    for (k = 0; k < DEPTH; k++) begin
      mem[k] = {fill_inst(BASE + k * 8 + 4), fill_inst(BASE + k * 8)};
    end
    o_rdata = '0;
  endtask

  task automatic write_inst(input logic [31:0] addr, input logic [31:0] inst);
    if (addr[2]) begin
      mem[addr[8:3]][63:32] = inst;
    end else begin
      mem[addr[8:3]][31:0] = inst;
    end
  endtask

  always @(posedge i_clk) begin
    if (i_ren) begin
      o_rdata <= read_word(i_addr);  // one cycle read latency
    end
  end

endmodule

`default_nettype wire

//--- dv/fe_tb.sv
// fetch front end testbench
`timescale 1ns/1ps
`default_nettype none

module fe_tb;

  localparam int          HALF_PERIOD  = 50;
  localparam int          DRIVE_DLY    = 10;    // after the rising edge
  localparam int          RESET_CYCLES = 16;
  localparam int          WAIT_LIMIT   = 200;   // cycles per expected entry
  localparam logic [31:0] BASE         = 32'h8000_0000;
  localparam logic [6:0]  JAL_OPC      = 7'b110_1111;
  localparam int          N_NOP        = 14;
  localparam int          N_JAL        = 9;
  localparam int          N_EXP        = 27;

  logic              i_clk;
  logic              i_reset;
  logic              i_es_allowin;
  logic              o_inst_sram_ren;
  logic [31:0]       o_inst_sram_addr;
  logic [63:0]       i_inst_sram_rdata;
  logic              o_ds_to_es_valid;
  fe_pkg::inst_bus_t o_ds_to_es_bus;

  // program slots as offsets from BASE, nop k carries immediate k+1
  logic [11:0] nop_at [N_NOP] = '{
    12'h000, 12'h004, 12'h008, 12'h00c, 12'h030, 12'h074, 12'h024,
    12'h028, 12'h0ac, 12'h0b0, 12'h080, 12'h0cc, 12'h100, 12'h104
  };
  // jal slots and their targets, forward and backward, both halves
  logic [11:0] jal_at [N_JAL] = '{
    12'h010, 12'h034, 12'h078, 12'h02c, 12'h0b4, 12'h084, 12'h08c, 12'h0d0, 12'h108
  };
  logic [11:0] jal_to [N_JAL] = '{
    12'h030, 12'h074, 12'h024, 12'h0ac, 12'h080, 12'h08c, 12'h0cc, 12'h100, 12'h100
  };
  // order execute must see, the slot after each jal never shows up
  logic [11:0] exp_at [N_EXP] = '{
    12'h000, 12'h004, 12'h008, 12'h00c, 12'h010, 12'h030, 12'h034,
    12'h074, 12'h078, 12'h024, 12'h028, 12'h02c, 12'h0ac, 12'h0b0,
    12'h0b4, 12'h080, 12'h084, 12'h08c, 12'h0cc, 12'h0d0, 12'h100,
    12'h104, 12'h108, 12'h100, 12'h104, 12'h108, 12'h100
  };

  int                errors;
  int                timeouts;
  int                checked;
  int                jal_held_cycles;  // jal in decode while execute stalls
  int                mode;
  bit                aborted;
  logic [31:0]       lcg_state;
  logic              held;
  fe_pkg::inst_bus_t held_bus;

  fe_top dut_i (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .i_es_allowin      (i_es_allowin),
    .o_ds_to_es_valid  (o_ds_to_es_valid),
    .o_ds_to_es_bus    (o_ds_to_es_bus)
  );

  fe_inst_mem inst_mem_i (
    .i_clk   (i_clk),
    .i_ren   (o_inst_sram_ren),
    .i_addr  (o_inst_sram_addr),
    .o_rdata (i_inst_sram_rdata)
  );

  initial begin
    i_clk = 1'b0;
    forever #HALF_PERIOD i_clk = ~i_clk;
  end

  // addi x0, x0, imm
  function automatic logic [31:0] nop_inst(input int imm);
    return {imm[11:0], 5'd0, 3'b000, 5'd0, 7'b001_0011};
  endfunction

  // jal x1 from one address to another
  function automatic logic [31:0] jal_inst(input logic [31:0] from, input logic [31:0] to);
    logic [31:0] off;
    off = to - from;
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, JAL_OPC};
  endfunction

  function automatic logic [31:0] prog_inst(input logic [31:0] addr);
    int          k;
    logic [31:0] found;
    found = 32'h0;
    for (k = 0; k < N_NOP; k++) begin
      if (BASE + nop_at[k] == addr) begin
        found = nop_inst(k + 1);
      end
    end
    for (k = 0; k < N_JAL; k++) begin
      if (BASE + jal_at[k] == addr) begin
        found = jal_inst(addr, BASE + jal_to[k]);
      end
    end
    return found;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // 0 always ready, 1 random with about a third low, 2 ready one cycle in three
  function automatic logic allowin_for(input int m, input int cyc, input logic [31:0] rnd);
    case (m)
      0:       return 1'b1;
      1:       return (rnd[31:16] % 3) != 0;
      default: return (cyc % 3) == 0;
    endcase
  endfunction

  task automatic load_program();
    int k;
    inst_mem_i.clear();
    for (k = 0; k < N_NOP; k++) begin
      inst_mem_i.write_inst(BASE + nop_at[k], nop_inst(k + 1));
    end
    for (k = 0; k < N_JAL; k++) begin
      inst_mem_i.write_inst(BASE + jal_at[k], jal_inst(BASE + jal_at[k], BASE + jal_to[k]));
    end
  endtask

  task automatic check_idle();
    if (o_inst_sram_ren !== 1'b0) begin
      $display("CHECK FAILED o_inst_sram_ren got 0x%0h expected 0x0 at %0t",
               o_inst_sram_ren, $time);
      errors++;
    end
    if (o_ds_to_es_valid !== 1'b0) begin
      $display("CHECK FAILED o_ds_to_es_valid got 0x%0h expected 0x0 at %0t",
               o_ds_to_es_valid, $time);
      errors++;
    end
  endtask

  // 16 edges with reset high, then one quiet cycle, ends just after an edge
  task automatic apply_reset();
    int cyc;
    i_reset      = 1'b1;
    i_es_allowin = 1'b0;
    for (cyc = 1; cyc <= RESET_CYCLES; cyc++) begin
      @(posedge i_clk);
      if (cyc < RESET_CYCLES) begin
        @(negedge i_clk);
        check_idle();
      end
    end
    #DRIVE_DLY;
    i_reset = 1'b0;
    @(negedge i_clk);
    check_idle();
    @(posedge i_clk);
    #DRIVE_DLY;
  endtask

  task automatic run_stream(input int m);
    int          idx;
    int          waited;
    int          cyc;
    logic [31:0] exp_pc;
    logic [31:0] exp_inst;
    idx    = 0;
    waited = 0;
    cyc    = 0;
    held   = 1'b0;
    while (idx < N_EXP && !aborted) begin
      lcg_state    = lcg_next(lcg_state);
      i_es_allowin = allowin_for(m, cyc, lcg_state);
      @(negedge i_clk);
      if (held && o_ds_to_es_valid !== 1'b1) begin
        $display("CHECK FAILED o_ds_to_es_valid got 0x%0h expected 0x1 while stalled",
                 o_ds_to_es_valid);
        errors++;
      end
      if (held && o_ds_to_es_bus !== held_bus) begin
        $display("CHECK FAILED o_ds_to_es_bus got 0x%h expected 0x%h while stalled",
                 o_ds_to_es_bus, held_bus);
        errors++;
      end
      held     = o_ds_to_es_valid && !i_es_allowin;
      held_bus = o_ds_to_es_bus;
      if (held && o_ds_to_es_bus.inst[6:0] == JAL_OPC) begin
        jal_held_cycles++;
      end
      if (o_ds_to_es_valid === 1'b1 && i_es_allowin) begin
        exp_pc   = BASE + exp_at[idx];
        exp_inst = prog_inst(exp_pc);
        if (o_ds_to_es_bus.pc !== exp_pc) begin
          $display("CHECK FAILED o_ds_to_es_bus.pc got 0x%08h expected 0x%08h (mode %0d entry %0d)",
                   o_ds_to_es_bus.pc, exp_pc, m, idx);
          errors++;
        end
        if (o_ds_to_es_bus.inst !== exp_inst) begin
          $display("CHECK FAILED o_ds_to_es_bus.inst got 0x%08h expected 0x%08h (mode %0d entry %0d)",
                   o_ds_to_es_bus.inst, exp_inst, m, idx);
          errors++;
        end
        checked++;
        idx++;
        waited = 0;
      end else begin
        waited++;
        if (waited >= WAIT_LIMIT) begin
          $display("timeout: nothing reached execute for %0d cycles (mode %0d entry %0d)",
                   WAIT_LIMIT, m, idx);
          timeouts++;
          aborted = 1'b1;
        end
      end
      @(posedge i_clk);
      #DRIVE_DLY;
      cyc++;
    end
  endtask

  initial begin
    i_reset         = 1'b1;
    i_es_allowin    = 1'b0;
    errors          = 0;
    timeouts        = 0;
    checked         = 0;
    jal_held_cycles = 0;
    aborted         = 1'b0;
    held            = 1'b0;
    lcg_state       = 32'h35b8_03d8;
    load_program();
    for (mode = 0; mode < 3 && !aborted; mode++) begin
      apply_reset();
      run_stream(mode);
    end
    if (jal_held_cycles == 0 && !aborted) begin
      $display("no JAL was ever held in decode by execute back-pressure");
      errors++;
    end
    $display("%0d transfers checked, %0d errors, %0d timeouts", checked, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
design/fe_pkg.sv
design/fe_pc.sv
design/fe_if_stage.sv
design/fe_id_stage.sv
design/fe_top.sv
dv/fe_inst_mem.sv
dv/fe_tb.sv
